// ==== design/axil_mem_port.sv ====
// AXI4-Lite memory port adapter
`timescale 1ns/100ps
`default_nettype none

module axil_mem_port #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  wire                                 clk,
   input  wire                                 rst,
   // Write address and data
   input  wire  [mem_pkg::AXI_ADDR_WIDTH-1:0]  awaddr,
   input  wire                                 awvalid,
   output logic                                awready,
   input  wire  [mem_pkg::DATA_WIDTH-1:0]      wdata,
   input  wire  [mem_pkg::STRB_WIDTH-1:0]      wstrb,
   input  wire                                 wvalid,
   output logic                                wready,
   // Write response
   output logic [1:0]                          bresp,
   output logic                                bvalid,
   input  wire                                 bready,
   // Read address and data
   input  wire  [mem_pkg::AXI_ADDR_WIDTH-1:0]  araddr,
   input  wire                                 arvalid,
   output logic                                arready,
   output logic [mem_pkg::DATA_WIDTH-1:0]      rdata,
   output logic [1:0]                          rresp,
   output logic                                rvalid,
   input  wire                                 rready,
   mem_if.client                               bus
);

   typedef enum logic [2:0] {
      S_IDLE,
      S_COLLECT,
      S_ISSUE,
      S_WAIT_RD,
      S_RESP
   } state_t;

   state_t                            state;

   // Channel handshakes
   logic                              aw_hs;
   logic                              w_hs;
   logic                              ar_hs;
   logic                              ar_ready_q;

   // Write halves received so far
   logic                              aw_have_q;
   logic                              w_have_q;
   logic                              wr_done;
   logic [mem_pkg::AXI_ADDR_WIDTH-1:0] wr_addr_now;

   // Captured transaction
   logic                              is_wr_q;
   logic [mem_pkg::AXI_ADDR_WIDTH-1:0] addr_q;
   logic [mem_pkg::DATA_WIDTH-1:0]    wdata_q;
   logic [mem_pkg::STRB_WIDTH-1:0]    wstrb_q;
   logic [1:0]                        resp_q;

   // Any bit at or above the memory size is out of range
   function automatic logic out_of_range(input logic [mem_pkg::AXI_ADDR_WIDTH-1:0] a);
      return (a >> MEM_ADDR_WIDTH) != '0;
   endfunction

   // Reads held off while a write is on offer
   assign arready = ar_ready_q & ~awvalid & ~wvalid;

   assign aw_hs = awvalid & awready;
   assign w_hs  = wvalid & wready;
   assign ar_hs = arvalid & arready;

   assign wr_done     = (aw_have_q | aw_hs) & (w_have_q | w_hs);
   assign wr_addr_now = aw_hs ? awaddr : addr_q;

   //////////////////////////////
   // Transaction FSM
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= S_IDLE;
         awready    <= 1'b0;
         wready     <= 1'b0;
         ar_ready_q <= 1'b0;
         aw_have_q  <= 1'b0;
         w_have_q   <= 1'b0;
         is_wr_q    <= 1'b0;
         bvalid     <= 1'b0;
         rvalid     <= 1'b0;
      end else begin
         case (state)
            S_IDLE, S_COLLECT: begin
               if (aw_hs) begin
                  addr_q    <= awaddr;
                  awready   <= 1'b0;
                  aw_have_q <= 1'b1;
               end
               if (w_hs) begin
                  wdata_q  <= wdata;
                  wstrb_q  <= wstrb;
                  wready   <= 1'b0;
                  w_have_q <= 1'b1;
               end
               if (wr_done) begin
                  is_wr_q    <= 1'b1;
                  ar_ready_q <= 1'b0;
                  // Bad write skips the memory entirely
                  if (out_of_range(wr_addr_now)) begin
                     resp_q <= mem_pkg::RESP_SLVERR;
                     bvalid <= 1'b1;
                     state  <= S_RESP;
                  end else begin
                     state <= S_ISSUE;
                  end
               end else if (aw_hs || w_hs) begin
                  ar_ready_q <= 1'b0;
                  state      <= S_COLLECT;
               end else if (ar_hs) begin
                  addr_q     <= araddr;
                  is_wr_q    <= 1'b0;
                  awready    <= 1'b0;
                  wready     <= 1'b0;
                  ar_ready_q <= 1'b0;
                  if (out_of_range(araddr)) begin
                     resp_q <= mem_pkg::RESP_SLVERR;
                     rdata  <= '0;
                     rvalid <= 1'b1;
                     state  <= S_RESP;
                  end else begin
                     state <= S_ISSUE;
                  end
               end else if (state == S_IDLE) begin
                  // Open all channels
                  awready    <= 1'b1;
                  wready     <= 1'b1;
                  ar_ready_q <= 1'b1;
               end
            end

            S_ISSUE: begin
               if (bus.gnt) begin
                  if (is_wr_q) begin
                     resp_q <= mem_pkg::RESP_OKAY;
                     bvalid <= 1'b1;
                     state  <= S_RESP;
                  end else begin
                     state <= S_WAIT_RD;
                  end
               end
            end

            // Capture on return so the memory never waits
            S_WAIT_RD: begin
               if (bus.rvalid) begin
                  rdata  <= bus.rdata;
                  resp_q <= mem_pkg::RESP_OKAY;
                  rvalid <= 1'b1;
                  state  <= S_RESP;
               end
            end

            // Hold until the master takes it
            S_RESP: begin
               if ((bvalid && bready) || (rvalid && rready)) begin
                  bvalid     <= 1'b0;
                  rvalid     <= 1'b0;
                  aw_have_q  <= 1'b0;
                  w_have_q   <= 1'b0;
                  awready    <= 1'b1;
                  wready     <= 1'b1;
                  ar_ready_q <= 1'b1;
                  state      <= S_IDLE;
               end
            end

            default: state <= S_IDLE;
         endcase
      end
   end

   assign bresp = resp_q;
   assign rresp = resp_q;

   // Request fields stay stable through the whole issue state
   assign bus.req   = (state == S_ISSUE);
   assign bus.wr    = is_wr_q;
   assign bus.addr  = addr_q[MEM_ADDR_WIDTH-1:0];
   assign bus.wdata = wdata_q;
   assign bus.wstrb = wstrb_q;

endmodule

`default_nettype wire

// ==== design/dual_port_mem_sys.sv ====
// Dual AXI4-Lite shared memory
`timescale 1ns/100ps
`default_nettype none

module dual_port_mem_sys #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  wire                                 clk,
   input  wire                                 rst,
   // Port 0
   input  wire  [mem_pkg::AXI_ADDR_WIDTH-1:0]  s0_awaddr,
   input  wire                                 s0_awvalid,
   output logic                                s0_awready,
   input  wire  [mem_pkg::DATA_WIDTH-1:0]      s0_wdata,
   input  wire  [mem_pkg::STRB_WIDTH-1:0]      s0_wstrb,
   input  wire                                 s0_wvalid,
   output logic                                s0_wready,
   output logic [1:0]                          s0_bresp,
   output logic                                s0_bvalid,
   input  wire                                 s0_bready,
   input  wire  [mem_pkg::AXI_ADDR_WIDTH-1:0]  s0_araddr,
   input  wire                                 s0_arvalid,
   output logic                                s0_arready,
   output logic [mem_pkg::DATA_WIDTH-1:0]      s0_rdata,
   output logic [1:0]                          s0_rresp,
   output logic                                s0_rvalid,
   input  wire                                 s0_rready,
   // Port 1
   input  wire  [mem_pkg::AXI_ADDR_WIDTH-1:0]  s1_awaddr,
   input  wire                                 s1_awvalid,
   output logic                                s1_awready,
   input  wire  [mem_pkg::DATA_WIDTH-1:0]      s1_wdata,
   input  wire  [mem_pkg::STRB_WIDTH-1:0]      s1_wstrb,
   input  wire                                 s1_wvalid,
   output logic                                s1_wready,
   output logic [1:0]                          s1_bresp,
   output logic                                s1_bvalid,
   input  wire                                 s1_bready,
   input  wire  [mem_pkg::AXI_ADDR_WIDTH-1:0]  s1_araddr,
   input  wire                                 s1_arvalid,
   output logic                                s1_arready,
   output logic [mem_pkg::DATA_WIDTH-1:0]      s1_rdata,
   output logic [1:0]                          s1_rresp,
   output logic                                s1_rvalid,
   input  wire                                 s1_rready
);

   //////////////////////////////
   // Internal buses
   //////////////////////////////

   // Port to arbiter
   mem_if #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) port_bus0 ();
   mem_if #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) port_bus1 ();

   // Arbiter to storage
   mem_if #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) mem_bus ();

   //////////////////////////////
   // AXI port adapters
   //////////////////////////////

   axil_mem_port #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) port0_i (
      .clk     (clk),
      .rst     (rst),
      .awaddr  (s0_awaddr),
      .awvalid (s0_awvalid),
      .awready (s0_awready),
      .wdata   (s0_wdata),
      .wstrb   (s0_wstrb),
      .wvalid  (s0_wvalid),
      .wready  (s0_wready),
      .bresp   (s0_bresp),
      .bvalid  (s0_bvalid),
      .bready  (s0_bready),
      .araddr  (s0_araddr),
      .arvalid (s0_arvalid),
      .arready (s0_arready),
      .rdata   (s0_rdata),
      .rresp   (s0_rresp),
      .rvalid  (s0_rvalid),
      .rready  (s0_rready),
      .bus     (port_bus0.client)
   );

   axil_mem_port #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) port1_i (
      .clk     (clk),
      .rst     (rst),
      .awaddr  (s1_awaddr),
      .awvalid (s1_awvalid),
      .awready (s1_awready),
      .wdata   (s1_wdata),
      .wstrb   (s1_wstrb),
      .wvalid  (s1_wvalid),
      .wready  (s1_wready),
      .bresp   (s1_bresp),
      .bvalid  (s1_bvalid),
      .bready  (s1_bready),
      .araddr  (s1_araddr),
      .arvalid (s1_arvalid),
      .arready (s1_arready),
      .rdata   (s1_rdata),
      .rresp   (s1_rresp),
      .rvalid  (s1_rvalid),
      .rready  (s1_rready),
      .bus     (port_bus1.client)
   );

   // Shared memory behind one arbiter
   mem_arbiter #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) arbiter_i (
      .clk   (clk),
      .rst   (rst),
      .port0 (port_bus0.server),
      .port1 (port_bus1.server),
      .mem   (mem_bus.client)
   );

   pipelined_mem #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) mem_i (
      .clk (clk),
      .rst (rst),
      .bus (mem_bus.server)
   );

endmodule

`default_nettype wire

// ==== design/mem_arbiter.sv ====
// Round-robin memory arbiter
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  wire    clk,
   input  wire    rst,
   mem_if.server  port0,
   mem_if.server  port1,
   mem_if.client  mem
);

   localparam int TAG_WIDTH = $clog2(mem_pkg::NUM_PORTS);
   localparam int LAST      = mem_pkg::READ_LATENCY - 1;

   // Selected port this cycle and port granted most recently
   logic [TAG_WIDTH-1:0]              sel;
   logic [TAG_WIDTH-1:0]              last_gnt;

   // Muxed request address
   logic [MEM_ADDR_WIDTH-1:0]         sel_addr;

   // Request accepted by the memory
   logic                              mem_take;

   // Port tags of reads in flight
   logic [TAG_WIDTH-1:0]              tag_port [mem_pkg::READ_LATENCY];
   logic [mem_pkg::READ_LATENCY-1:0]  tag_valid;
   logic                              ret_valid;

   //////////////////////////////
   // Grant
   //////////////////////////////

   // Tie goes to the port not granted last
   always_comb begin
      if (port0.req && port1.req) begin
         sel = ~last_gnt;
      end else if (port1.req) begin
         sel = TAG_WIDTH'(1);
      end else begin
         sel = TAG_WIDTH'(0);
      end
   end

   // Forward the winner's fields
   always_comb begin
      if (sel == TAG_WIDTH'(0)) begin
         mem.wr    = port0.wr;
         sel_addr  = port0.addr;
         mem.wdata = port0.wdata;
         mem.wstrb = port0.wstrb;
      end else begin
         mem.wr    = port1.wr;
         sel_addr  = port1.addr;
         mem.wdata = port1.wdata;
         mem.wstrb = port1.wstrb;
      end
   end

   assign mem.addr = sel_addr;
   assign mem.req  = port0.req | port1.req;
   assign mem_take = mem.req & mem.gnt;

   assign port0.gnt = mem_take & (sel == TAG_WIDTH'(0));
   assign port1.gnt = mem_take & (sel == TAG_WIDTH'(1));

   // Priority rotates on every accepted request
   always_ff @(posedge clk) begin
      if (rst) begin
         last_gnt <= TAG_WIDTH'(1);
      end else if (mem_take) begin
         last_gnt <= sel;
      end
   end

   //////////////////////////////
   // Read return routing
   //////////////////////////////

   // Mirrors the memory read pipeline depth
   always_ff @(posedge clk) begin
      if (rst) begin
         tag_valid <= '0;
      end else begin
         tag_valid <= {tag_valid[LAST-1:0], mem_take & ~mem.wr};
      end
   end

   always_ff @(posedge clk) begin
      tag_port[0] <= sel;
      for (int i = 1; i < mem_pkg::READ_LATENCY; i++) begin
         tag_port[i] <= tag_port[i-1];
      end
   end

   assign ret_valid = mem.rvalid & tag_valid[LAST];

   // Data goes to both, valid only to the requester
   assign port0.rvalid = ret_valid & (tag_port[LAST] == TAG_WIDTH'(0));
   assign port1.rvalid = ret_valid & (tag_port[LAST] == TAG_WIDTH'(1));
   assign port0.rdata  = mem.rdata;
   assign port1.rdata  = mem.rdata;

endmodule

`default_nettype wire

// ==== design/mem_if.sv ====
// Memory request and return bus
`timescale 1ns/100ps
`default_nettype none

interface mem_if #(
   parameter int MEM_ADDR_WIDTH = 12
);

   // Request, from the client
   logic                            req;
   logic                            wr;
   logic [MEM_ADDR_WIDTH-1:0]       addr;
   logic [mem_pkg::DATA_WIDTH-1:0]  wdata;
   logic [mem_pkg::STRB_WIDTH-1:0]  wstrb;

   // Grant and read return, from the memory side
   logic                            gnt;
   logic                            rvalid;
   logic [mem_pkg::DATA_WIDTH-1:0]  rdata;

   // Requester view
   modport client (
      output req, wr, addr, wdata, wstrb,
      input  gnt, rvalid, rdata
   );

   // Memory or arbiter view
   modport server (
      input  req, wr, addr, wdata, wstrb,
      output gnt, rvalid, rdata
   );

endinterface

`default_nettype wire

// ==== design/mem_pkg.sv ====
// Shared memory system definitions
`default_nettype none

package mem_pkg;

   //////////////////////////////
   // Data path
   //////////////////////////////

   // Memory word and AXI data width
   parameter int DATA_WIDTH = 16;

   // One strobe per byte lane
   parameter int STRB_WIDTH = DATA_WIDTH / 8;

   // Byte address width seen on the AXI ports
   parameter int AXI_ADDR_WIDTH = 16;

   //////////////////////////////
   // Memory and arbitration
   //////////////////////////////

   // Cycles from read grant to read data valid
   parameter int READ_LATENCY = 4;

   // Number of peer AXI ports sharing the memory
   parameter int NUM_PORTS = 2;

   // AXI response codes
   parameter logic [1:0] RESP_OKAY   = 2'b00;
   parameter logic [1:0] RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

// ==== design/pipelined_mem.sv ====
// Strobed memory with pipelined read
`timescale 1ns/100ps
`default_nettype none

module pipelined_mem #(
   parameter int MEM_ADDR_WIDTH = 12
) (
   input  wire    clk,
   input  wire    rst,
   mem_if.server  bus
);

   localparam int WORDS      = 2 ** (MEM_ADDR_WIDTH - 1);
   localparam int BYTE_WIDTH = mem_pkg::DATA_WIDTH / mem_pkg::STRB_WIDTH;
   localparam int LAST       = mem_pkg::READ_LATENCY - 1;

   // Word storage, one entry per 16-bit word
   logic [mem_pkg::DATA_WIDTH-1:0]    mem_array [WORDS];

   // Byte address with bit 0 dropped
   logic [MEM_ADDR_WIDTH-2:0]         word_addr;

   // Read return shift chains
   logic [mem_pkg::DATA_WIDTH-1:0]    rd_data_pipe [mem_pkg::READ_LATENCY];
   logic [mem_pkg::READ_LATENCY-1:0]  rd_valid_pipe;

   assign word_addr = bus.addr[MEM_ADDR_WIDTH-1:1];

   // Never stalls
   assign bus.gnt = 1'b1;

   //////////////////////////////
   // Write port
   //////////////////////////////

   // Only lanes with a set strobe change
   always_ff @(posedge clk) begin
      if (bus.req && bus.wr) begin
         for (int b = 0; b < mem_pkg::STRB_WIDTH; b++) begin
            if (bus.wstrb[b]) begin
               mem_array[word_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                  bus.wdata[b*BYTE_WIDTH +: BYTE_WIDTH];
            end
         end
      end
   end

   //////////////////////////////
   // Read pipeline
   //////////////////////////////

   // Stage 0 samples the array at the grant edge
   always_ff @(posedge clk) begin
      rd_data_pipe[0] <= mem_array[word_addr];
      for (int i = 1; i < mem_pkg::READ_LATENCY; i++) begin
         rd_data_pipe[i] <= rd_data_pipe[i-1];
      end
   end

   // Valid bits track each granted read, several may be in flight
   always_ff @(posedge clk) begin
      if (rst) begin
         rd_valid_pipe <= '0;
      end else begin
         rd_valid_pipe <= {rd_valid_pipe[LAST-1:0], bus.req & ~bus.wr};
      end
   end

   assign bus.rdata  = rd_data_pipe[LAST];
   assign bus.rvalid = rd_valid_pipe[LAST];

endmodule

`default_nettype wire

// ==== src.f ====
design/mem_pkg.sv
design/mem_if.sv
design/pipelined_mem.sv
design/mem_arbiter.sv
design/axil_mem_port.sv
design/dual_port_mem_sys.sv
testbench/tb_dual_port_mem_sys.sv

// ==== testbench/tb_dual_port_mem_sys.sv ====
// Dual port memory testbench
`timescale 1ns/100ps
`default_nettype none

module tb_dual_port_mem_sys;

   localparam int MEM_AW    = 12;
   localparam int TIMEOUT   = 100;
   localparam int CONC_BASE = 16'h0200;

   logic                                     clk;
   logic                                     rst;

   // Index 0 is port s0 and index 1 is port s1
   logic [1:0][mem_pkg::AXI_ADDR_WIDTH-1:0]  awaddr;
   logic [1:0]                               awvalid;
   logic [1:0][mem_pkg::DATA_WIDTH-1:0]      wdata;
   logic [1:0][mem_pkg::STRB_WIDTH-1:0]      wstrb;
   logic [1:0]                               wvalid;
   logic [1:0]                               bready;
   logic [1:0][mem_pkg::AXI_ADDR_WIDTH-1:0]  araddr;
   logic [1:0]                               arvalid;
   logic [1:0]                               rready;
   wire  [1:0]                               awready;
   wire  [1:0]                               wready;
   wire  [1:0][1:0]                          bresp;
   wire  [1:0]                               bvalid;
   wire  [1:0]                               arready;
   wire  [1:0][mem_pkg::DATA_WIDTH-1:0]      rdata;
   wire  [1:0][1:0]                          rresp;
   wire  [1:0]                               rvalid;

   // Reference copy of the memory with one entry per word
   logic [mem_pkg::DATA_WIDTH-1:0]           model [2 ** (MEM_AW - 1)];
   logic [31:0]                              lcg_state;
   int                                       errors;
   int                                       timeouts;

   always #20 clk = ~clk;

   dual_port_mem_sys #(.MEM_ADDR_WIDTH(MEM_AW)) dual_port_mem_sys_i (
      .clk        (clk),
      .rst        (rst),
      .s0_awaddr  (awaddr[0]),
      .s0_awvalid (awvalid[0]),
      .s0_awready (awready[0]),
      .s0_wdata   (wdata[0]),
      .s0_wstrb   (wstrb[0]),
      .s0_wvalid  (wvalid[0]),
      .s0_wready  (wready[0]),
      .s0_bresp   (bresp[0]),
      .s0_bvalid  (bvalid[0]),
      .s0_bready  (bready[0]),
      .s0_araddr  (araddr[0]),
      .s0_arvalid (arvalid[0]),
      .s0_arready (arready[0]),
      .s0_rdata   (rdata[0]),
      .s0_rresp   (rresp[0]),
      .s0_rvalid  (rvalid[0]),
      .s0_rready  (rready[0]),
      .s1_awaddr  (awaddr[1]),
      .s1_awvalid (awvalid[1]),
      .s1_awready (awready[1]),
      .s1_wdata   (wdata[1]),
      .s1_wstrb   (wstrb[1]),
      .s1_wvalid  (wvalid[1]),
      .s1_wready  (wready[1]),
      .s1_bresp   (bresp[1]),
      .s1_bvalid  (bvalid[1]),
      .s1_bready  (bready[1]),
      .s1_araddr  (araddr[1]),
      .s1_arvalid (arvalid[1]),
      .s1_arready (arready[1]),
      .s1_rdata   (rdata[1]),
      .s1_rresp   (rresp[1]),
      .s1_rvalid  (rvalid[1]),
      .s1_rready  (rready[1])
   );

   //////////////////////////////
   // Helpers
   //////////////////////////////

   // LCG with numerical recipes constants
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Upper half of the next LCG value as a data word
   function automatic logic [15:0] rand_word();
      logic [31:0] r;
      r = next_rand();
      return r[31:16];
   endfunction

   // Byte lane merge under strobes
   function automatic logic [15:0] merge_bytes(input logic [15:0] old_data,
                                               input logic [15:0] new_data,
                                               input logic [1:0]  strb);
      logic [15:0] res;
      res = old_data;
      if (strb[0]) res[7:0] = new_data[7:0];
      if (strb[1]) res[15:8] = new_data[15:8];
      return res;
   endfunction

   //////////////////////////////
   // AXI4-Lite master tasks
   //////////////////////////////

   // Split puts AW one cycle or more ahead of W
   task automatic axil_write(input int p, input logic [15:0] addr, input logic [15:0] data,
                             input logic [1:0] strb, input bit split, input int hold,
                             input logic [1:0] exp_resp);
      int         cnt;
      bit         aw_done;
      bit         w_done;
      logic [1:0] held;
      aw_done = 1'b0;
      w_done  = 1'b0;
      cnt     = 0;
      @(posedge clk);
      awaddr[p]  <= addr;
      awvalid[p] <= 1'b1;
      wdata[p]   <= data;
      wstrb[p]   <= strb;
      wvalid[p]  <= !split;
      while (!(aw_done && w_done) && cnt < TIMEOUT) begin
         @(posedge clk);
         cnt++;
         if (wvalid[p] && wready[p]) begin
            w_done = 1'b1;
            wvalid[p] <= 1'b0;
         end
         if (awvalid[p] && awready[p]) begin
            aw_done = 1'b1;
            awvalid[p] <= 1'b0;
            // W follows only after AW
            if (split) wvalid[p] <= 1'b1;
         end
      end
      if (!(aw_done && w_done)) begin
         timeouts++;
         $display("Timeout: port %0d write address or data handshake never finished", p);
         awvalid[p] <= 1'b0;
         wvalid[p]  <= 1'b0;
      end
      bready[p] <= (hold == 0);
      cnt = 0;
      do begin
         @(posedge clk);
         cnt++;
      end while (!bvalid[p] && cnt < TIMEOUT);
      if (!bvalid[p]) begin
         timeouts++;
         $display("Timeout: port %0d write response never arrived", p);
      end else begin
         held = bresp[p];
         // Response must sit still while bready is low
         for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            if (bvalid[p] !== 1'b1) begin
               errors++;
               $display("Error: port %0d bvalid expected 1 got %h", p, bvalid[p]);
            end
            if (bresp[p] !== held) begin
               errors++;
               $display("Error: port %0d bresp expected %h got %h", p, held, bresp[p]);
            end
            if (awready[p] || wready[p] || arready[p]) begin
               errors++;
               $display("Error: port %0d opened an address channel with a response pending", p);
            end
            if (i == hold - 1) bready[p] <= 1'b1;
         end
         if (hold > 0) @(posedge clk);
         if (bresp[p] !== exp_resp) begin
            errors++;
            $display("Error: port %0d bresp expected %h got %h", p, exp_resp, bresp[p]);
         end
      end
      bready[p] <= 1'b0;
   endtask

   task automatic axil_read(input int p, input logic [15:0] addr, input int hold,
                            input logic [15:0] exp_data, input logic [1:0] exp_resp);
      int          cnt;
      bit          ar_done;
      logic [15:0] held_data;
      logic [1:0]  held_resp;
      ar_done = 1'b0;
      cnt     = 0;
      @(posedge clk);
      araddr[p]  <= addr;
      arvalid[p] <= 1'b1;
      while (!ar_done && cnt < TIMEOUT) begin
         @(posedge clk);
         cnt++;
         if (arvalid[p] && arready[p]) begin
            ar_done = 1'b1;
            arvalid[p] <= 1'b0;
         end
      end
      if (!ar_done) begin
         timeouts++;
         $display("Timeout: port %0d read address handshake never finished", p);
         arvalid[p] <= 1'b0;
      end
      rready[p] <= (hold == 0);
      cnt = 0;
      do begin
         @(posedge clk);
         cnt++;
      end while (!rvalid[p] && cnt < TIMEOUT);
      if (!rvalid[p]) begin
         timeouts++;
         $display("Timeout: port %0d read data never arrived", p);
      end else begin
         held_data = rdata[p];
         held_resp = rresp[p];
         for (int i = 0; i < hold; i++) begin
            @(posedge clk);
            if (rvalid[p] !== 1'b1) begin
               errors++;
               $display("Error: port %0d rvalid expected 1 got %h", p, rvalid[p]);
            end
            if (rdata[p] !== held_data) begin
               errors++;
               $display("Error: port %0d rdata expected %h got %h", p, held_data, rdata[p]);
            end
            if (rresp[p] !== held_resp) begin
               errors++;
               $display("Error: port %0d rresp expected %h got %h", p, held_resp, rresp[p]);
            end
            if (awready[p] || wready[p] || arready[p]) begin
               errors++;
               $display("Error: port %0d opened an address channel with a response pending", p);
            end
            if (i == hold - 1) rready[p] <= 1'b1;
         end
         if (hold > 0) @(posedge clk);
         if (rdata[p] !== exp_data) begin
            errors++;
            $display("Error: port %0d rdata expected %h got %h", p, exp_data, rdata[p]);
         end
         if (rresp[p] !== exp_resp) begin
            errors++;
            $display("Error: port %0d rresp expected %h got %h", p, exp_resp, rresp[p]);
         end
      end
      rready[p] <= 1'b0;
   endtask

   // In-range write and matching model update
   task automatic write_word(input int p, input logic [15:0] addr, input logic [15:0] data,
                             input logic [1:0] strb, input bit split, input int hold);
      axil_write(p, addr, data, strb, split, hold, mem_pkg::RESP_OKAY);
      model[addr[MEM_AW-1:1]] = merge_bytes(model[addr[MEM_AW-1:1]], data, strb);
   endtask

   task automatic read_word(input int p, input logic [15:0] addr, input int hold);
      axil_read(p, addr, hold, model[addr[MEM_AW-1:1]], mem_pkg::RESP_OKAY);
   endtask

   // Each port keeps to its own words so results do not depend on port order
   task automatic random_op(input int p, input logic [31:0] r);
      logic [15:0] addr;
      addr = 16'(CONC_BASE) + {9'b0, r[8:4], 2'b00} + 16'(p * 2);
      if (r[0]) write_word(p, addr, r[31:16], r[3:2], r[1], 0);
      else read_word(p, addr, 0);
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////

   task automatic test_write_read();
      write_word(0, 16'h0010, rand_word(), 2'b11, 1'b0, 0);
      read_word(0, 16'h0010, 0);
      // AW ahead of W
      write_word(0, 16'h0022, rand_word(), 2'b11, 1'b1, 0);
      read_word(0, 16'h0022, 0);
   endtask

   task automatic test_byte_strobes();
      write_word(0, 16'h0040, 16'ha55a, 2'b11, 1'b0, 0);
      write_word(0, 16'h0040, 16'h1234, 2'b01, 1'b0, 0);
      read_word(0, 16'h0040, 0);
      write_word(1, 16'h0040, 16'hbeef, 2'b10, 1'b0, 0);
      read_word(0, 16'h0040, 0);
   endtask

   task automatic test_cross_port();
      write_word(1, 16'h0080, rand_word(), 2'b11, 1'b0, 0);
      read_word(0, 16'h0080, 0);
      write_word(0, 16'h0082, rand_word(), 2'b11, 1'b0, 0);
      read_word(1, 16'h0082, 0);
   endtask

   // Addresses at or above 4 KiB alias onto 0x100 and 0x102
   task automatic test_range_check();
      write_word(0, 16'h0100, 16'h0f0f, 2'b11, 1'b0, 0);
      write_word(1, 16'h0102, 16'hf0f0, 2'b11, 1'b0, 0);
      axil_write(0, 16'h1100, 16'hdead, 2'b11, 1'b0, 0, mem_pkg::RESP_SLVERR);
      axil_write(1, 16'h8102, 16'hdead, 2'b11, 1'b1, 0, mem_pkg::RESP_SLVERR);
      axil_read(0, 16'h1100, 0, 16'h0000, mem_pkg::RESP_SLVERR);
      axil_read(1, 16'hf102, 0, 16'h0000, mem_pkg::RESP_SLVERR);
      read_word(0, 16'h0100, 0);
      read_word(1, 16'h0102, 0);
   endtask

   task automatic test_concurrent();
      logic [15:0] d0;
      logic [15:0] d1;
      logic [31:0] r0;
      logic [31:0] r1;
      // Fill both regions first
      for (int w = 0; w < 32; w++) begin
         d0 = rand_word();
         d1 = rand_word();
         fork
            write_word(0, 16'(CONC_BASE + w * 4), d0, 2'b11, 1'b0, 0);
            write_word(1, 16'(CONC_BASE + w * 4 + 2), d1, 2'b11, 1'b0, 0);
         join
      end
      for (int n = 0; n < 60; n++) begin
         r0 = next_rand();
         r1 = next_rand();
         fork
            random_op(0, r0);
            random_op(1, r1);
         join
      end
   endtask

   task automatic test_back_pressure();
      write_word(0, 16'h0300, rand_word(), 2'b11, 1'b0, 5);
      read_word(0, 16'h0300, 6);
      write_word(1, 16'h0302, rand_word(), 2'b11, 1'b1, 3);
      read_word(1, 16'h0302, 4);
      // Port still usable after the stall
      read_word(0, 16'h0302, 0);
   endtask

   //////////////////////////////
   // Main sequence
   //////////////////////////////

   initial begin
      clk       = 1'b0;
      rst       = 1'b1;
      awaddr    = '0;
      awvalid   = '0;
      wdata     = '0;
      wstrb     = '0;
      wvalid    = '0;
      bready    = '0;
      araddr    = '0;
      arvalid   = '0;
      rready    = '0;
      lcg_state = 32'hff38fd2b;
      errors    = 0;
      timeouts  = 0;
      repeat (4) @(posedge clk);
      rst <= 1'b0;
      test_write_read();
      test_byte_strobes();
      test_cross_port();
      test_range_check();
      test_concurrent();
      test_back_pressure();
      repeat (5) @(posedge clk);
      $display("Summary: %0d value errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

`default_nettype wire
